//--- Bender.yml
package:
  name: harness_fabric

sources:
  - files:
      - src/harness_pkg.sv
      - src/bus_decoder.sv
      - src/boot_rom.sv
      - src/sram_bank.sv
      - src/harness_regs.sv
      - src/debug_req_gate.sv
      - src/harness_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_harness.sv

//--- all.f
+incdir+verification
src/harness_pkg.sv
src/bus_decoder.sv
src/boot_rom.sv
src/sram_bank.sv
src/harness_regs.sv
src/debug_req_gate.sv
src/harness_top.sv
verification/tb_harness.sv

//--- src/boot_rom.sv
// Boot ROM returning one image word per request with a registered read port
`timescale 1ns/1ps

module boot_rom (
  input  logic                  clk_i,
  input  logic                  sys_rst_ni,
  input  harness_pkg::bus_req_t req_i,
  output harness_pkg::data_t    rdata_o
);
  import harness_pkg::*;

  logic [ROM_AW-1:0] word_idx;
  data_t             rdata_q;

  // Word index inside the ROM window
  assign word_idx = req_i.addr[ROM_AW+BYTE_OFS-1:BYTE_OFS];

  always_ff @(posedge clk_i or negedge sys_rst_ni) begin
    if (!sys_rst_ni) begin
      rdata_q <= '0;
    end else if (req_i.req) begin
      rdata_q <= ROM_IMAGE[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- src/bus_decoder.sv
// Address decoder with target steering, error flagging and registered response mux
`timescale 1ns/1ps

module bus_decoder (
  input  logic                clk_i,
  input  logic                ndmreset_n,
  input  harness_pkg::bus_req_t bus_req_i,
  output harness_pkg::bus_req_t regs_req_o,
  output harness_pkg::bus_req_t rom_req_o,
  output harness_pkg::bus_req_t sram_req_o,
  input  harness_pkg::data_t  regs_rdata_i,
  input  harness_pkg::data_t  rom_rdata_i,
  input  harness_pkg::data_t  sram_rdata_i,
  output harness_pkg::bus_rsp_t bus_rsp_o
);
  import harness_pkg::*;

  logic    hit_regs, hit_rom, hit_sram;
  logic    cycles_wr;
  logic    err_d, err_q;
  logic    valid_q;
  target_e sel_d, sel_q;

  // Offset compare also covers a base of zero
  function automatic logic in_window(addr_t addr, addr_t base, addr_t len);
    return (addr - base) < len;
  endfunction

  assign hit_regs  = in_window(bus_req_i.addr, REGS_BASE, REGS_LENGTH);
  assign hit_rom   = in_window(bus_req_i.addr, ROM_BASE, ROM_LENGTH);
  assign hit_sram  = in_window(bus_req_i.addr, SRAM_BASE, SRAM_LENGTH);
  assign cycles_wr = hit_regs & bus_req_i.we &
                     (bus_req_i.addr[REG_OFFSET_W-1:0] == REG_CYCLES_OFFSET);

  always_comb begin
    regs_req_o     = bus_req_i;
    rom_req_o      = bus_req_i;
    sram_req_o     = bus_req_i;
    regs_req_o.req = bus_req_i.req & hit_regs;
    rom_req_o.req  = bus_req_i.req & hit_rom & ~bus_req_i.we;
    sram_req_o.req = bus_req_i.req & hit_sram;
  end

  assign err_d = bus_req_i.req &
                 (~(hit_regs | hit_rom | hit_sram) | (hit_rom & bus_req_i.we) | cycles_wr);

  // Writes and misses return zero data
  always_comb begin
    sel_d = NONE;
    if (bus_req_i.req && !bus_req_i.we) begin
      if (hit_regs)      sel_d = REGS;
      else if (hit_rom)  sel_d = ROM;
      else if (hit_sram) sel_d = SRAM;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
      sel_q   <= NONE;
    end else begin
      valid_q <= bus_req_i.req;
      err_q   <= err_d;
      sel_q   <= sel_d;
    end
  end

  always_comb begin
    bus_rsp_o.rvalid = valid_q;
    bus_rsp_o.err    = err_q;
    case (sel_q)
      REGS:    bus_rsp_o.rdata = regs_rdata_i;
      ROM:     bus_rsp_o.rdata = rom_rdata_i;
      SRAM:    bus_rsp_o.rdata = sram_rdata_i;
      default: bus_rsp_o.rdata = '0;
    endcase
  end

endmodule

//--- src/debug_req_gate.sv
// Hold-off counter masking the debug request after power-on reset
`timescale 1ns/1ps

module debug_req_gate (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic dbg_req_i,
  output logic debug_req_o
);
  import harness_pkg::*;

  logic [DBG_CNT_W-1:0] cnt_q;
  logic                 hold;

  assign hold = (cnt_q != '0);

  // Counts down once per edge, sticks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DBG_CNT_W'(DEBUG_DELAY_CYCLES);
    end else if (hold) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = dbg_req_i & ~hold;

endmodule

//--- src/harness_pkg.sv
// Shared widths, bus structs, address map, register map and boot image of the harness fabric
package harness_pkg;

  // --------------------------------------------------------------------
  // Bus widths and types
  // --------------------------------------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;
  localparam int unsigned BYTE_OFS   = $clog2(BE_WIDTH);

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [BE_WIDTH-1:0]   be_t;
  typedef logic [31:0]           exit_t;
  typedef logic [31:0]           cycles_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    NONE,
    REGS,
    ROM,
    SRAM
  } target_e;

  // --------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------
  localparam addr_t REGS_BASE   = 32'h0000_0000;
  localparam addr_t REGS_LENGTH = 32'h0000_1000;

  localparam int unsigned ROM_WORDS  = 16;
  localparam int unsigned ROM_AW     = $clog2(ROM_WORDS);
  localparam addr_t       ROM_BASE   = 32'h0001_0000;
  localparam addr_t       ROM_LENGTH = 32'h0000_0080;

  localparam int unsigned SRAM_WORDS  = 1024;
  localparam int unsigned SRAM_AW     = 10;
  localparam addr_t       SRAM_BASE   = 32'h8000_0000;
  localparam addr_t       SRAM_LENGTH = addr_t'(SRAM_WORDS * BE_WIDTH);

  // Register block, offsets within REGS window
  localparam int unsigned REG_OFFSET_W = $clog2(REGS_LENGTH);
  localparam logic [REG_OFFSET_W-1:0] REG_CTRL_OFFSET   = 12'h000;
  localparam logic [REG_OFFSET_W-1:0] REG_EXIT_OFFSET   = 12'h008;
  localparam logic [REG_OFFSET_W-1:0] REG_CYCLES_OFFSET = 12'h010;

  localparam int unsigned CTRL_WIDTH        = 2;
  localparam int unsigned CTRL_DBG_BIT      = 0;
  localparam int unsigned CTRL_NDMRESET_BIT = 1;

  // Boot code gets this many cycles before a debug request
  localparam int unsigned DEBUG_DELAY_CYCLES = 500;
  localparam int unsigned DBG_CNT_W          = $clog2(DEBUG_DELAY_CYCLES + 1);

  localparam data_t ROM_IMAGE [ROM_WORDS] = '{
    64'h0000_0297_0202_8293, 64'h0010_0513_00a2_a023,
    64'h0000_0517_0505_0513, 64'h3050_1073_0000_0073,
    64'hf140_2573_0000_0597, 64'h0185_8593_0005_8067,
    64'h1050_0073_ffdf_f06f, 64'h0000_0013_0000_0013,
    64'hdead_beef_cafe_f00d, 64'h0123_4567_89ab_cdef,
    64'h8000_0000_0000_0000, 64'h0000_1000_0000_0800,
    64'h5a5a_a5a5_3c3c_c3c3, 64'hffff_0000_ffff_0000,
    64'h0f0f_0f0f_f0f0_f0f0, 64'h0000_0000_0000_0001
  };

endpackage

//--- src/harness_regs.sv
// Control, exit and cycle registers with soft-reset combining and reset synchronizer
`timescale 1ns/1ps

module harness_regs (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  harness_pkg::bus_req_t req_i,
  output harness_pkg::data_t    rdata_o,
  output logic                  sys_rst_no,
  output logic                  dbg_req_o,
  output harness_pkg::exit_t    exit_o
);
  import harness_pkg::*;

  logic [REG_OFFSET_W-1:0] offset;
  logic [CTRL_WIDTH-1:0]   ctrl_q;
  exit_t                   exit_q;
  cycles_t                 cycles_q;
  data_t                   rdata_d, rdata_q;
  logic                    rst_comb_n;
  logic                    rst_sync_q0, rst_sync_q1;

  assign offset = req_i.addr[REG_OFFSET_W-1:0];

  // --------------------------------------------------------------------
  // Register writes
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ctrl_q <= '0;
      exit_q <= '0;
    end else if (req_i.req && req_i.we) begin
      if (offset == REG_CTRL_OFFSET && req_i.be[0]) begin
        ctrl_q <= req_i.wdata[CTRL_WIDTH-1:0];
      end
      if (offset == REG_EXIT_OFFSET) begin
        for (int i = 0; i < $bits(exit_t) / 8; i++) begin
          if (req_i.be[i]) exit_q[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Read path, unknown offsets read as zero
  always_comb begin
    case (offset)
      REG_CTRL_OFFSET:   rdata_d = data_t'(ctrl_q);
      REG_EXIT_OFFSET:   rdata_d = data_t'(exit_q);
      REG_CYCLES_OFFSET: rdata_d = data_t'(cycles_q);
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) rdata_q <= rdata_d;
  end

  // --------------------------------------------------------------------
  // System reset
  // --------------------------------------------------------------------
  // Asserts at once, released two edges after the bit clears
  assign rst_comb_n = ndmreset_n & ~ctrl_q[CTRL_NDMRESET_BIT];

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      rst_sync_q0 <= 1'b0;
      rst_sync_q1 <= 1'b0;
    end else begin
      rst_sync_q0 <= 1'b1;
      rst_sync_q1 <= rst_sync_q0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_sync_q1) begin
    if (!rst_sync_q1) begin
      cycles_q <= '0;
    end else begin
      cycles_q <= cycles_q + 1'b1;
    end
  end

  assign sys_rst_no = rst_sync_q1;
  assign dbg_req_o  = ctrl_q[CTRL_DBG_BIT];
  assign exit_o     = exit_q;
  assign rdata_o    = rdata_q;

endmodule

//--- src/harness_top.sv
// Top level of the harness fabric connecting decoder, targets, registers and debug gate
`timescale 1ns/1ps

module harness_top (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  harness_pkg::bus_req_t bus_req_i,
  output harness_pkg::bus_rsp_t bus_rsp_o,
  output logic                  debug_req_o,
  output harness_pkg::exit_t    exit_o
);
  import harness_pkg::*;

  bus_req_t regs_req, rom_req, sram_req;
  data_t    regs_rdata, rom_rdata, sram_rdata;
  logic     sys_rst_n;
  logic     dbg_req;

  // --------------------------------------------------------------------
  // Interconnect
  // --------------------------------------------------------------------
  bus_decoder i_bus_decoder (
    .clk_i        ( clk_i      ),
    .ndmreset_n   ( ndmreset_n ),
    .bus_req_i    ( bus_req_i  ),
    .regs_req_o   ( regs_req   ),
    .rom_req_o    ( rom_req    ),
    .sram_req_o   ( sram_req   ),
    .regs_rdata_i ( regs_rdata ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_rdata_i ( sram_rdata ),
    .bus_rsp_o    ( bus_rsp_o  )
  );

  // --------------------------------------------------------------------
  // Targets
  // --------------------------------------------------------------------
  harness_regs i_harness_regs (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( regs_req   ),
    .rdata_o    ( regs_rdata ),
    .sys_rst_no ( sys_rst_n  ),
    .dbg_req_o  ( dbg_req    ),
    .exit_o     ( exit_o     )
  );

  boot_rom i_boot_rom (
    .clk_i      ( clk_i     ),
    .sys_rst_ni ( sys_rst_n ),
    .req_i      ( rom_req   ),
    .rdata_o    ( rom_rdata )
  );

  sram_bank i_sram_bank (
    .clk_i   ( clk_i      ),
    .req_i   ( sram_req   ),
    .rdata_o ( sram_rdata )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .dbg_req_i   ( dbg_req     ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- src/sram_bank.sv
// Word-addressed data SRAM with byte-enable writes and registered read data
`timescale 1ns/1ps

module sram_bank (
  input  logic                  clk_i,
  input  harness_pkg::bus_req_t req_i,
  output harness_pkg::data_t    rdata_o
);
  import harness_pkg::*;

  data_t              mem [SRAM_WORDS];
  logic [SRAM_AW-1:0] word_idx;
  data_t              rdata_q;

  assign word_idx = req_i.addr[SRAM_AW+BYTE_OFS-1:BYTE_OFS];

  // --------------------------------------------------------------------
  // Array access
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int i = 0; i < BE_WIDTH; i++) begin
          if (req_i.be[i]) begin
            mem[word_idx][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- verification/tb_model.svh
// Reference model: LCG, SRAM, control and exit shadows, address decode and expected responses
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int unsigned LCG_SEED        = 84;
localparam int unsigned SRAM_TEST_WORDS = 64;

typedef struct packed {
  logic  err;
  logic  rdata_chk;
  data_t rdata;
} expect_t;

logic [31:0]           lcg_state  = LCG_SEED;
data_t                 sram_shadow [SRAM_WORDS];
logic [CTRL_WIDTH-1:0] ctrl_model = '0;
exit_t                 exit_model = '0;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// Low LCG bits have short periods
function automatic int unsigned rand_below(int unsigned n);
  return (lcg_next() >> 12) % n;
endfunction

function automatic data_t rand64();
  logic [31:0] hi;
  logic [31:0] lo;
  hi = lcg_next();
  lo = lcg_next();
  return {hi, lo};
endfunction

// Initial SRAM contents, unique per byte address
function automatic data_t fill_word(addr_t addr);
  return {addr, ~addr};
endfunction

function automatic logic window_hit(addr_t addr, addr_t base, addr_t len);
  return (addr >= base) && (addr <= base + (len - 1));
endfunction

function automatic target_e decode_target(addr_t addr);
  if (window_hit(addr, REGS_BASE, REGS_LENGTH)) return REGS;
  if (window_hit(addr, ROM_BASE, ROM_LENGTH)) return ROM;
  if (window_hit(addr, SRAM_BASE, addr_t'(SRAM_WORDS * BE_WIDTH))) return SRAM;
  return NONE;
endfunction

// Applies one request to the shadows and returns the response it must produce
function automatic expect_t model_access(logic we, addr_t addr, be_t be, data_t wdata);
  expect_t     exp;
  int unsigned idx;
  addr_t       ofs;
  exp.err       = 1'b0;
  exp.rdata_chk = 1'b1;
  exp.rdata     = '0;
  case (decode_target(addr))
    ROM: begin
      idx       = (addr - ROM_BASE) / BE_WIDTH;
      exp.err   = we;
      exp.rdata = ROM_IMAGE[idx];
    end
    SRAM: begin
      idx       = (addr - SRAM_BASE) / BE_WIDTH;
      exp.rdata = sram_shadow[idx];
      for (int i = 0; i < BE_WIDTH; i++) begin
        if (we && be[i]) sram_shadow[idx][8*i +: 8] = wdata[8*i +: 8];
      end
    end
    REGS: begin
      ofs = addr - REGS_BASE;
      if (ofs == addr_t'(REG_CTRL_OFFSET)) begin
        exp.rdata = data_t'(ctrl_model);
        if (we && be[0]) ctrl_model = wdata[CTRL_WIDTH-1:0];
      end else if (ofs == addr_t'(REG_EXIT_OFFSET)) begin
        exp.rdata = data_t'(exit_model);
        for (int i = 0; i < $bits(exit_t) / 8; i++) begin
          if (we && be[i]) exit_model[8*i +: 8] = wdata[8*i +: 8];
        end
      end else if (ofs == addr_t'(REG_CYCLES_OFFSET)) begin
        // Read value is only bounded
        exp.err       = we;
        exp.rdata_chk = we;
      end
    end
    default: exp.err = 1'b1;
  endcase
  if (we || exp.err) exp.rdata = '0;
  return exp;
endfunction

`endif

//--- verification/tb_harness.sv
// Harness fabric testbench with clock, reset, random bus traffic, checks, watchdog and report
`timescale 1ns/1ps

module tb_harness;
  import harness_pkg::*;

  `include "tb_model.svh"

  localparam int unsigned CLK_PERIOD      = 20;
  localparam int unsigned SRAM_RANDOM_OPS = 200;
  localparam int unsigned UNMAPPED_OPS    = 20;
  localparam int unsigned RECHECK_OPS     = 16;
  // Fill, random, ROM, unmapped, debug, exit, soft reset and recheck traffic
  localparam int unsigned NUM_OPS = SRAM_TEST_WORDS + SRAM_RANDOM_OPS + ROM_WORDS + 2 +
                                    UNMAPPED_OPS + 1 + 2 + 2 + 3 + 1 + RECHECK_OPS;
  localparam longint unsigned WATCHDOG_NS =
    longint'(NUM_OPS + DEBUG_DELAY_CYCLES + 200) * CLK_PERIOD;

  logic     clk_i;
  logic     ndmreset_n;
  bus_req_t bus_req;
  bus_rsp_t bus_rsp;
  logic     debug_req;
  exit_t    exit_code;

  expect_t     exp_queue [$];
  data_t       last_rdata;
  logic        req_sampled = 1'b0;
  int unsigned edge_cnt    = 0;
  int unsigned check_count = 0;
  int unsigned error_count = 0;

  harness_top harness_top_inst (
    .clk_i       ( clk_i      ),
    .ndmreset_n  ( ndmreset_n ),
    .bus_req_i   ( bus_req    ),
    .bus_rsp_o   ( bus_rsp    ),
    .debug_req_o ( debug_req  ),
    .exit_o      ( exit_code  )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Edges since power-on reset release
  always @(posedge clk_i) begin
    if (ndmreset_n) edge_cnt <= edge_cnt + 1;
  end

  // Request seen by the DUT at the last rising edge
  always @(posedge clk_i) begin
    req_sampled <= bus_req.req;
  end

  // ----------------------------------------------------------------------
  // Checking
  // ----------------------------------------------------------------------
  task automatic check_value(input string what, input data_t actual, input data_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin : response_check
    expect_t exp;
    check_value("rvalid", data_t'(bus_rsp.rvalid), data_t'(req_sampled));
    if (bus_rsp.rvalid) begin
      if (exp_queue.size() == 0) begin
        error_count++;
        $display("Response at %0t ns arrived with no request outstanding", $time);
      end else begin
        exp        = exp_queue.pop_front();
        last_rdata = bus_rsp.rdata;
        check_value("err", data_t'(bus_rsp.err), data_t'(exp.err));
        if (exp.rdata_chk) check_value("rdata", bus_rsp.rdata, exp.rdata);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Bus driving
  // ----------------------------------------------------------------------
  task automatic issue_op(input logic we, input addr_t addr, input be_t be, input data_t wdata);
    bus_req_t req;
    req.req   = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.be    = be;
    req.wdata = wdata;
    @(posedge clk_i);
    bus_req <= req;
    exp_queue.push_back(model_access(we, addr, be, wdata));
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    bus_req.req <= 1'b0;
  endtask

  task automatic wait_drain();
    idle_cycle();
    while (exp_queue.size() != 0) @(negedge clk_i);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    addr_t       addr;
    data_t       wval;
    be_t         be;
    logic        we;
    int unsigned idx;
    int unsigned clear_edge;
    int unsigned read_edge;

    ndmreset_n = 1'b0;
    bus_req    = '0;
    repeat (2) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    @(negedge clk_i);
    check_value("rvalid after reset", data_t'(bus_rsp.rvalid), '0);
    check_value("err after reset", data_t'(bus_rsp.err), '0);
    check_value("debug_req_o after reset", data_t'(debug_req), '0);
    check_value("exit_o after reset", data_t'(exit_code), '0);

    // Debug request hold-off
    issue_op(1'b1, REGS_BASE + REG_CTRL_OFFSET, '1, data_t'(1) << CTRL_DBG_BIT);
    wait_drain();
    while (edge_cnt < DEBUG_DELAY_CYCLES + 4) begin
      @(negedge clk_i);
      check_value("debug_req_o", data_t'(debug_req), data_t'(edge_cnt >= DEBUG_DELAY_CYCLES));
    end
    issue_op(1'b1, REGS_BASE + REG_CTRL_OFFSET, '1, '0);
    wait_drain();
    check_value("debug_req_o after clear", data_t'(debug_req), '0);

    // SRAM fill and random traffic with occasional gaps
    for (int w = 0; w < SRAM_TEST_WORDS; w++) begin
      addr = SRAM_BASE + addr_t'(w * BE_WIDTH);
      issue_op(1'b1, addr, '1, fill_word(addr));
    end
    for (int n = 0; n < SRAM_RANDOM_OPS; n++) begin
      idx  = rand_below(SRAM_TEST_WORDS);
      we   = (rand_below(2) == 1);
      be   = be_t'(rand_below(256));
      wval = rand64();
      issue_op(we, SRAM_BASE + addr_t'(idx * BE_WIDTH), be, wval);
      if (rand_below(8) == 0) idle_cycle();
    end
    wait_drain();

    // Boot ROM
    for (int w = 0; w < ROM_WORDS; w++) begin
      issue_op(1'b0, ROM_BASE + addr_t'(w * BE_WIDTH), '0, '0);
    end
    idx  = rand_below(ROM_WORDS);
    wval = rand64();
    issue_op(1'b1, ROM_BASE + addr_t'(idx * BE_WIDTH), '1, wval);
    issue_op(1'b0, ROM_BASE + addr_t'(idx * BE_WIDTH), '0, '0);
    wait_drain();

    // Unmapped space and the read-only cycle register
    for (int n = 0; n < UNMAPPED_OPS; n++) begin
      do begin
        addr = lcg_next() & ~addr_t'(BE_WIDTH - 1);
      end while (decode_target(addr) != NONE);
      wval = rand64();
      issue_op(n % 2 == 1, addr, '1, wval);
    end
    wval = rand64();
    issue_op(1'b1, REGS_BASE + REG_CYCLES_OFFSET, '1, wval);
    wait_drain();

    // Exit code
    wval = rand64();
    issue_op(1'b1, REGS_BASE + REG_EXIT_OFFSET, '1, wval);
    idle_cycle();
    @(negedge clk_i);
    check_value("exit_o", data_t'(exit_code), data_t'(exit_model));
    issue_op(1'b0, REGS_BASE + REG_EXIT_OFFSET, '0, '0);
    wait_drain();

    // Soft reset pulse and counter restart after release
    issue_op(1'b1, REGS_BASE + REG_CTRL_OFFSET, '1, data_t'(1) << CTRL_NDMRESET_BIT);
    repeat (3) idle_cycle();
    issue_op(1'b1, REGS_BASE + REG_CTRL_OFFSET, '1, '0);
    clear_edge = edge_cnt;
    repeat (10) idle_cycle();
    issue_op(1'b0, REGS_BASE + REG_CYCLES_OFFSET, '0, '0);
    read_edge = edge_cnt;
    wait_drain();
    check_value("cycle count within bound",
                data_t'(last_rdata <= data_t'(read_edge - clear_edge - 2)), data_t'(1));

    // State kept across the soft reset
    issue_op(1'b0, REGS_BASE + REG_EXIT_OFFSET, '0, '0);
    for (int n = 0; n < RECHECK_OPS; n++) begin
      idx = rand_below(SRAM_TEST_WORDS);
      issue_op(1'b0, SRAM_BASE + addr_t'(idx * BE_WIDTH), '0, '0);
    end
    wait_drain();
    check_value("exit_o after soft reset", data_t'(exit_code), data_t'(exit_model));

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
